// File: rtl/controlFsm.sv
module controlFsm (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   start,
  input  logic                   pcIsZero,
  input  logic                   waitrequest,
  input  logic                   stall,
  input  logic                   takeBranch,
  input  controlPkg::instrClassT cls,
  output controlPkg::stateT      state,
  output logic                   branchDelay,
  output logic                   active
);
  import controlPkg::*;

  stateT nextState;
  logic  exec1Done;
  logic  laterDone;

  always_comb begin
    case (state)
      FETCH, STALL: nextState = waitrequest ? STALL : DECODE;
      DECODE:       nextState = EXEC1;
      EXEC1: begin
        if (stall) begin
          nextState = EXEC1;
        end else begin
          nextState = (cls.lastStep == EXEC1) ? FETCH : EXEC2;
        end
      end
      EXEC2: begin
        if (waitrequest) begin
          nextState = EXEC2;
        end else begin
          nextState = (cls.lastStep == EXEC2) ? FETCH : EXEC3;
        end
      end
      EXEC3:   nextState = FETCH;
      HALTED:  nextState = start ? FETCH : HALTED;
      default: nextState = HALTED;
    endcase

    // PC of zero ends the run from any running state
    if (state != HALTED && pcIsZero) begin
      nextState = HALTED;
    end
  end

  assign exec1Done = state == EXEC1 && !stall;
  assign laterDone = (state == EXEC2 && !waitrequest) || state == EXEC3;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state       <= HALTED;
      branchDelay <= 1'b0;
    end else begin
      state <= nextState;
      if (nextState == HALTED) begin
        branchDelay <= 1'b0;
      end else if (exec1Done) begin
        branchDelay <= takeBranch;
      end else if (laterDone) begin
        branchDelay <= 1'b0;
      end
    end
  end

  assign active = state != HALTED;

  stateLegal: assert property (@(posedge clk) disable iff (!rstN)
    state inside {FETCH, DECODE, EXEC1, EXEC2, EXEC3, HALTED, STALL});

  // Only loads run a third exec step
  exec3OnlyForLoads: assert property (@(posedge clk) disable iff (!rstN)
    state == EXEC3 |-> $past(cls.lastStep) == EXEC3);

endmodule

// File: rtl/controlPkg.sv
package controlPkg;

  // Major opcodes handled by the control unit
  typedef enum logic [5:0] {
    R_TYPE = 6'b000000,
    J      = 6'b000010,
    JAL    = 6'b000011,
    BEQ    = 6'b000100,
    BNE    = 6'b000101,
    ADDIU  = 6'b001001,
    ANDI   = 6'b001100,
    ORI    = 6'b001101,
    XORI   = 6'b001110,
    LB     = 6'b100000,
    LH     = 6'b100001,
    LW     = 6'b100011,
    LBU    = 6'b100100,
    LHU    = 6'b100101,
    SW     = 6'b101011
  } opcodeT;

  // R-type function codes
  typedef enum logic [5:0] {
    FN_JR   = 6'b001000,
    FN_ADDU = 6'b100001,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101
  } functT;

  typedef enum logic [2:0] {
    FETCH  = 3'b000,
    DECODE = 3'b001,
    EXEC1  = 3'b010,
    EXEC2  = 3'b011,
    EXEC3  = 3'b100,
    HALTED = 3'b101,
    STALL  = 3'b110
  } stateT;

  // ALU operation codes as seen by the datapath ALU
  typedef enum logic [4:0] {
    ALU_AND        = 5'b00000,
    ALU_OR         = 5'b00001,
    ALU_ADD        = 5'b00010,
    ALU_XOR        = 5'b00011,
    ALU_COMPARE_EQ = 5'b01010,
    ALU_PASS_B     = 5'b01011,
    ALU_PASS_A     = 5'b01110,
    ALU_R_FUNCT    = 5'b01111,
    ALU_ADD_UPPER  = 5'b10001
  } aluOpT;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFieldsT;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
  } iFieldsT;

  // Jump target sits in the low 26 bits of either view
  typedef union packed {
    rFieldsT rFields;
    iFieldsT iFields;
  } instrWordT;

  typedef enum logic [1:0] {
    WORD = 2'd0,
    HALF = 2'd1,
    BYTE = 2'd2
  } loadWidthT;

  typedef enum logic [3:0] {
    ALU_REG,
    ALU_IMM,
    LOAD,
    STORE,
    BRANCH_EQ,
    BRANCH_NE,
    JUMP,
    JUMP_REG,
    UNSUPPORTED
  } instrKindT;

  typedef struct packed {
    instrKindT kind;
    logic      link;
    aluOpT     aluOp;
    logic      zeroExtend;
    loadWidthT width;
    logic      signedLoad;
    stateT     lastStep;
  } instrClassT;

  typedef struct packed {
    logic       aluSrcA;
    logic [1:0] aluSrcB;
    aluOpT      aluControl;
    logic       aluSel;
    logic       extSel;
    logic       regDst;
    logic       memToReg;
    logic       regWrite;
    logic       pcSrc;
    logic       irWrite;
    logic       irSel;
    logic       pcWrite;
    logic       isJump;
    logic       link;
  } dpCtrlT;

  typedef struct packed {
    logic       memRead;
    logic       memWrite;
    logic       iorD;
    logic [3:0] byteEnable;
    logic [1:0] extendMem;
  } memCtrlT;

  localparam logic [3:0] byteEnWord = 4'b1111;
  localparam logic [3:0] byteEnHalf = 4'b0011;
  localparam logic [3:0] byteEnByte = 4'b0001;

  // ALU source B selections
  localparam logic [1:0] aluSrcBReg     = 2'b00;
  localparam logic [1:0] aluSrcBFour    = 2'b01;
  localparam logic [1:0] aluSrcBImm     = 2'b10;
  localparam logic [1:0] aluSrcBShifted = 2'b11;

endpackage

// File: rtl/cpuControl.sv
module cpuControl (
  input  logic                  clk,
  input  logic                  rstN,
  input  controlPkg::instrWordT instr,
  input  logic                  start,
  input  logic                  pcIsZero,
  input  logic                  waitrequest,
  input  logic                  stall,
  input  logic                  aluFlag,
  output controlPkg::dpCtrlT    dpCtrl,
  output controlPkg::memCtrlT   memCtrl,
  output logic                  active,
  output controlPkg::stateT     state,
  output logic                  branchDelay
);

  controlPkg::instrClassT cls;
  logic                   takeBranch;

  instrClassifier instrClassifier_inst (
    .instr (instr),
    .cls   (cls)
  );

  controlFsm controlFsm_inst (
    .clk         (clk),
    .rstN        (rstN),
    .start       (start),
    .pcIsZero    (pcIsZero),
    .waitrequest (waitrequest),
    .stall       (stall),
    .takeBranch  (takeBranch),
    .cls         (cls),
    .state       (state),
    .branchDelay (branchDelay),
    .active      (active)
  );

  datapathCtrlGen datapathCtrlGen_inst (
    .state       (state),
    .cls         (cls),
    .branchDelay (branchDelay),
    .aluFlag     (aluFlag),
    .dpCtrl      (dpCtrl),
    .takeBranch  (takeBranch)
  );

  memCtrlGen memCtrlGen_inst (
    .state   (state),
    .cls     (cls),
    .memCtrl (memCtrl)
  );

endmodule

// File: rtl/datapathCtrlGen.sv
module datapathCtrlGen (
  input  controlPkg::stateT      state,
  input  controlPkg::instrClassT cls,
  input  logic                   branchDelay,
  input  logic                   aluFlag,
  output controlPkg::dpCtrlT     dpCtrl,
  output logic                   takeBranch
);
  import controlPkg::*;

  logic finalStep;
  logic writesReg;

  assign finalStep = state == cls.lastStep;
  assign writesReg = cls.kind inside {ALU_REG, ALU_IMM, LOAD};

  always_comb begin
    dpCtrl            = '0;
    dpCtrl.aluControl = ALU_ADD;
    dpCtrl.aluSrcB    = aluSrcBReg;
    dpCtrl.irSel      = state != DECODE;

    // Writeback happens in the final step only
    dpCtrl.regWrite = finalStep && writesReg;
    dpCtrl.regDst   = finalStep && cls.kind == ALU_REG;
    dpCtrl.memToReg = finalStep && cls.kind == LOAD;

    case (state)
      FETCH: begin
        dpCtrl.pcWrite = 1'b1;
        dpCtrl.pcSrc   = branchDelay;
        dpCtrl.aluSrcA = 1'b0;
        dpCtrl.aluSrcB = aluSrcBFour;
      end
      // Branch target precomputed while the register file is read
      DECODE: begin
        dpCtrl.irWrite = 1'b1;
        dpCtrl.aluSrcB = aluSrcBShifted;
        if (cls.kind == JUMP) begin
          dpCtrl.extSel     = 1'b1;
          dpCtrl.aluControl = ALU_PASS_B;
        end
      end
      EXEC1: begin
        dpCtrl.aluControl = cls.aluOp;
        dpCtrl.extSel     = cls.zeroExtend;
        case (cls.kind)
          ALU_REG, BRANCH_EQ, BRANCH_NE: begin
            dpCtrl.aluSrcA = 1'b1;
            dpCtrl.aluSrcB = aluSrcBReg;
            dpCtrl.aluSel  = cls.kind != ALU_REG;
          end
          ALU_IMM, LOAD, STORE: begin
            dpCtrl.aluSrcA = 1'b1;
            dpCtrl.aluSrcB = aluSrcBImm;
          end
          JUMP: begin
            dpCtrl.isJump  = 1'b1;
            dpCtrl.link    = cls.link;
            dpCtrl.extSel  = 1'b1;
            dpCtrl.aluSrcB = cls.link ? aluSrcBFour : aluSrcBShifted;
          end
          JUMP_REG: dpCtrl.aluSrcA = 1'b1;
          default: ;
        endcase
      end
      // ALU register feeds writeback or the memory address
      EXEC2: dpCtrl.aluSel = cls.kind inside {ALU_REG, ALU_IMM, LOAD, STORE};
      default: ;
    endcase
  end

  always_comb begin
    case (cls.kind)
      BRANCH_EQ:      takeBranch = aluFlag;
      BRANCH_NE:      takeBranch = !aluFlag;
      JUMP, JUMP_REG: takeBranch = 1'b1;
      default:        takeBranch = 1'b0;
    endcase
  end

endmodule

// File: rtl/instrClassifier.sv
module instrClassifier (
  input  controlPkg::instrWordT  instr,
  output controlPkg::instrClassT cls
);
  import controlPkg::*;

  always_comb begin
    cls.kind       = UNSUPPORTED;
    cls.link       = 1'b0;
    cls.aluOp      = ALU_ADD;
    cls.zeroExtend = 1'b0;
    cls.width      = WORD;
    cls.signedLoad = 1'b0;

    case (instr.iFields.opcode)
      R_TYPE: begin
        case (instr.rFields.funct)
          FN_ADDU, FN_AND, FN_OR: begin
            cls.kind  = ALU_REG;
            cls.aluOp = ALU_R_FUNCT;
          end
          FN_JR: begin
            cls.kind  = JUMP_REG;
            cls.aluOp = ALU_PASS_A;
          end
          default: ;
        endcase
      end
      ADDIU: cls.kind = ALU_IMM;
      ANDI, ORI, XORI: begin
        cls.kind       = ALU_IMM;
        cls.zeroExtend = 1'b1;
        if (instr.iFields.opcode == ANDI) begin
          cls.aluOp = ALU_AND;
        end else if (instr.iFields.opcode == ORI) begin
          cls.aluOp = ALU_OR;
        end else begin
          cls.aluOp = ALU_XOR;
        end
      end
      LW: cls.kind = LOAD;
      LH, LHU: begin
        cls.kind       = LOAD;
        cls.width      = HALF;
        cls.signedLoad = instr.iFields.opcode == LH;
      end
      LB, LBU: begin
        cls.kind       = LOAD;
        cls.width      = BYTE;
        cls.signedLoad = instr.iFields.opcode == LB;
      end
      SW: cls.kind = STORE;
      BEQ: begin
        cls.kind  = BRANCH_EQ;
        cls.aluOp = ALU_COMPARE_EQ;
      end
      BNE: begin
        cls.kind  = BRANCH_NE;
        cls.aluOp = ALU_COMPARE_EQ;
      end
      J: begin
        cls.kind  = JUMP;
        cls.aluOp = ALU_ADD_UPPER;
      end
      // JAL computes the return address in its exec step
      JAL: begin
        cls.kind = JUMP;
        cls.link = 1'b1;
      end
      default: ;
    endcase

    // Exit step by class; unsupported words retire after EXEC1
    case (cls.kind)
      ALU_REG, ALU_IMM, STORE: cls.lastStep = EXEC2;
      LOAD:                    cls.lastStep = EXEC3;
      default:                 cls.lastStep = EXEC1;
    endcase
  end

endmodule

// File: rtl/memCtrlGen.sv
module memCtrlGen (
  input  controlPkg::stateT      state,
  input  controlPkg::instrClassT cls,
  output controlPkg::memCtrlT    memCtrl
);
  import controlPkg::*;

  logic loadStep;

  // Width and extension stay valid through the load writeback
  assign loadStep = cls.kind == LOAD && state inside {EXEC2, EXEC3};

  always_comb begin
    memCtrl.memRead  = state inside {FETCH, STALL} ||
                       (state == EXEC2 && cls.kind == LOAD);
    memCtrl.memWrite = state == EXEC2 && cls.kind == STORE;
    memCtrl.iorD     = state == EXEC2;

    memCtrl.byteEnable = byteEnWord;
    memCtrl.extendMem  = 2'b00;
    if (loadStep) begin
      case (cls.width)
        HALF:    memCtrl.byteEnable = byteEnHalf;
        BYTE:    memCtrl.byteEnable = byteEnByte;
        default: memCtrl.byteEnable = byteEnWord;
      endcase
      // 2'b11 sign-extends a half, 2'b10 a byte
      if (cls.signedLoad && cls.width != WORD) begin
        memCtrl.extendMem = {1'b1, cls.width == HALF};
      end
    end
  end

endmodule

// File: tb.f
rtl/controlPkg.sv
rtl/instrClassifier.sv
rtl/controlFsm.sv
rtl/datapathCtrlGen.sv
rtl/memCtrlGen.sv
rtl/cpuControl.sv
testbench/controlChecker.sv
testbench/tbCpuControl.sv

// File: testbench/controlChecker.sv
module controlChecker (
  input  logic                  clk,
  input  logic                  rstN,
  input  controlPkg::instrWordT instr,
  input  logic                  start,
  input  logic                  pcIsZero,
  input  logic                  waitrequest,
  input  logic                  stall,
  input  logic                  aluFlag,
  input  controlPkg::dpCtrlT    dpCtrl,
  input  controlPkg::memCtrlT   memCtrl,
  input  logic                  active,
  input  controlPkg::stateT     state,
  input  logic                  branchDelay,
  input  logic                  endOfRun,
  output int                    errorCount
);
  timeunit 1ns;
  timeprecision 100ps;
  import controlPkg::*;

  typedef struct packed {
    stateT state;
    logic  branchDelay;
  } stepT;

  localparam int numTests   = 6;
  localparam int resetTest  = 0;
  localparam int seqTest    = 1;
  localparam int memTest    = 2;
  localparam int wbTest     = 3;
  localparam int branchTest = 4;
  localparam int haltTest   = 5;

  string testName [numTests] = '{"reset", "sequencing", "memory", "writeback", "branch",
                                 "halt"};
  int    checkCount [numTests] = '{default: 0};
  int    failCount [numTests] = '{default: 0};
  stepT  model;
  stateT lastState;
  logic  lastPcIsZero;

  initial errorCount = 0;

  function automatic logic isLoad(instrWordT w);
    return w.iFields.opcode inside {LW, LH, LHU, LB, LBU};
  endfunction

  function automatic logic isRAlu(instrWordT w);
    return w.iFields.opcode == R_TYPE && w.rFields.funct inside {FN_ADDU, FN_AND, FN_OR};
  endfunction

  function automatic logic isImmAlu(instrWordT w);
    return w.iFields.opcode inside {ADDIU, ANDI, ORI, XORI};
  endfunction

  // Branches and jumps take 3 cycles, ALU and stores 4, loads 5
  function automatic stateT exitStep(instrWordT w);
    if (isLoad(w)) begin
      return EXEC3;
    end
    if (isRAlu(w) || isImmAlu(w) || w.iFields.opcode == SW) begin
      return EXEC2;
    end
    return EXEC1;
  endfunction

  function automatic logic branchTaken(instrWordT w, logic flag);
    case (w.iFields.opcode)
      BEQ:     return flag;
      BNE:     return !flag;
      J, JAL:  return 1'b1;
      R_TYPE:  return w.rFields.funct == FN_JR;
      default: return 1'b0;
    endcase
  endfunction

  // Reference model of one clock step
  function automatic stepT refNext(stepT now, instrWordT w, logic go, logic pcZero,
                                   logic memWait, logic dpStall, logic flag);
    stepT  nxt;
    stateT last;
    last = exitStep(w);
    nxt  = now;
    case (now.state)
      FETCH, STALL: nxt.state = memWait ? STALL : DECODE;
      DECODE:       nxt.state = EXEC1;
      EXEC1: begin
        if (!dpStall) begin
          nxt.state       = (last == EXEC1) ? FETCH : EXEC2;
          nxt.branchDelay = branchTaken(w, flag);
        end
      end
      EXEC2: begin
        if (!memWait) begin
          nxt.state       = (last == EXEC2) ? FETCH : EXEC3;
          nxt.branchDelay = 1'b0;
        end
      end
      EXEC3: begin
        nxt.state       = FETCH;
        nxt.branchDelay = 1'b0;
      end
      default: nxt.state = go ? FETCH : HALTED;
    endcase
    if (now.state != HALTED && pcZero) begin
      nxt.state       = HALTED;
      nxt.branchDelay = 1'b0;
    end
    return nxt;
  endfunction

  task automatic checkValue(input int test, input string what, input logic [7:0] expected,
                            input logic [7:0] actual);
    checkCount[test]++;
    if (actual !== expected) begin
      failCount[test]++;
      errorCount++;
      $display("Mismatch in test %s: %s expected %h actual %h at %0t ns", testName[test],
               what, expected, actual, $time);
    end
  endtask

  task automatic compareCycle();
    int         seq;
    stateT      last;
    logic       load;
    logic [3:0] mask;
    logic [1:0] ext;
    seq  = (lastPcIsZero && lastState != HALTED) ? haltTest :
           (lastState == HALTED) ? resetTest : seqTest;
    last = exitStep(instr);
    load = isLoad(instr);
    checkValue(seq, "state", model.state, state);
    checkValue(seq, "active", model.state != HALTED, active);
    checkValue(seqTest, "pcWrite", model.state == FETCH, dpCtrl.pcWrite);
    checkValue(branchTest, "branchDelay", model.branchDelay, branchDelay);
    if (model.state == FETCH) begin
      checkValue(branchTest, "pcSrc", model.branchDelay, dpCtrl.pcSrc);
    end
    checkValue(branchTest, "link", model.state == EXEC1 && instr.iFields.opcode == JAL,
               dpCtrl.link);
    checkValue(wbTest, "regWrite",
               model.state == last && (isRAlu(instr) || isImmAlu(instr) || load),
               dpCtrl.regWrite);
    checkValue(wbTest, "regDst", model.state == last && isRAlu(instr), dpCtrl.regDst);
    checkValue(wbTest, "memToReg", model.state == last && load, dpCtrl.memToReg);

    // Load width and extension hold through the load's last two steps
    mask = byteEnWord;
    ext  = 2'b00;
    if (load && model.state inside {EXEC2, EXEC3}) begin
      if (instr.iFields.opcode inside {LH, LHU}) begin
        mask = byteEnHalf;
      end else if (instr.iFields.opcode inside {LB, LBU}) begin
        mask = byteEnByte;
      end
      if (instr.iFields.opcode == LH) begin
        ext = 2'b11;
      end else if (instr.iFields.opcode == LB) begin
        ext = 2'b10;
      end
    end
    checkValue(memTest, "memRead",
               model.state inside {FETCH, STALL} || (model.state == EXEC2 && load),
               memCtrl.memRead);
    checkValue(memTest, "memWrite", model.state == EXEC2 && instr.iFields.opcode == SW,
               memCtrl.memWrite);
    checkValue(memTest, "iorD", model.state == EXEC2, memCtrl.iorD);
    checkValue(memTest, "byteEnable", mask, memCtrl.byteEnable);
    checkValue(memTest, "extendMem", ext, memCtrl.extendMem);
  endtask

  // Inputs and outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!rstN) begin
      model.state       = HALTED;
      model.branchDelay = 1'b0;
      lastState         = HALTED;
      lastPcIsZero      = 1'b0;
      checkValue(resetTest, "state", HALTED, state);
      checkValue(resetTest, "active", 1'b0, active);
      checkValue(resetTest, "pcWrite", 1'b0, dpCtrl.pcWrite);
      checkValue(resetTest, "regWrite", 1'b0, dpCtrl.regWrite);
      checkValue(resetTest, "memRead", 1'b0, memCtrl.memRead);
      checkValue(resetTest, "memWrite", 1'b0, memCtrl.memWrite);
      checkValue(resetTest, "branchDelay", 1'b0, branchDelay);
    end else begin
      compareCycle();
      lastState    = model.state;
      lastPcIsZero = pcIsZero;
      model        = refNext(model, instr, start, pcIsZero, waitrequest, stall, aluFlag);
    end
  end

  always @(posedge endOfRun) begin
    int totalChecks;
    totalChecks = 0;
    for (int i = 0; i < numTests; i++) begin
      totalChecks += checkCount[i];
      if (checkCount[i] == 0) begin
        errorCount++;
        $display("Test %s never ran a single check", testName[i]);
      end else begin
        $display("Test %s: %0d checks, %0d failures", testName[i], checkCount[i],
                 failCount[i]);
      end
    end
    $display("Totals: %0d tests, %0d checks, %0d errors", numTests, totalChecks, errorCount);
  end

endmodule

// File: testbench/tbCpuControl.sv
module tbCpuControl;
  timeunit 1ns;
  timeprecision 100ps;
  import controlPkg::*;

  localparam int numInstr     = 300;
  localparam int clkPeriod    = 40;
  localparam int resetCycles  = 16;
  localparam int watchdogTime = numInstr * 12 * clkPeriod;

  logic        clk = 1'b0;
  logic        rstN;
  instrWordT   instr;
  logic        start;
  logic        pcIsZero;
  logic        waitrequest;
  logic        stall;
  logic        aluFlag;
  dpCtrlT      dpCtrl;
  memCtrlT     memCtrl;
  logic        active;
  stateT       state;
  logic        branchDelay;
  logic        endOfRun;
  int          errorCount;
  logic [31:0] lfsr = 32'h359d2396;

  always #(clkPeriod / 2) clk = ~clk;

  cpuControl cpuControl_inst (
    .clk         (clk),
    .rstN        (rstN),
    .instr       (instr),
    .start       (start),
    .pcIsZero    (pcIsZero),
    .waitrequest (waitrequest),
    .stall       (stall),
    .aluFlag     (aluFlag),
    .dpCtrl      (dpCtrl),
    .memCtrl     (memCtrl),
    .active      (active),
    .state       (state),
    .branchDelay (branchDelay)
  );

  controlChecker controlChecker_inst (
    .clk         (clk),
    .rstN        (rstN),
    .instr       (instr),
    .start       (start),
    .pcIsZero    (pcIsZero),
    .waitrequest (waitrequest),
    .stall       (stall),
    .aluFlag     (aluFlag),
    .dpCtrl      (dpCtrl),
    .memCtrl     (memCtrl),
    .active      (active),
    .state       (state),
    .branchDelay (branchDelay),
    .endOfRun    (endOfRun),
    .errorCount  (errorCount)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsrNext(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  function automatic instrWordT makeInstr(int pick, logic [14:0] regs, logic [15:0] imm);
    instrWordT w;
    opcodeT    op;
    functT     fn;
    op = R_TYPE;
    fn = FN_ADDU;
    case (pick % 18)
      0:       fn = FN_ADDU;
      1:       fn = FN_AND;
      2:       fn = FN_OR;
      3:       fn = FN_JR;
      4:       op = ADDIU;
      5:       op = ANDI;
      6:       op = ORI;
      7:       op = XORI;
      8:       op = LW;
      9:       op = LH;
      10:      op = LHU;
      11:      op = LB;
      12:      op = LBU;
      13:      op = SW;
      14:      op = BEQ;
      15:      op = BNE;
      16:      op = J;
      default: op = JAL;
    endcase
    if (op == R_TYPE) begin
      w.rFields = {op, regs, 5'd0, fn};
    end else begin
      w.iFields = {op, regs[14:5], imm};
    end
    return w;
  endfunction

  initial begin
    logic [31:0] pick;
    logic [31:0] regs;
    logic [31:0] imm;
    logic [31:0] bits;
    int          count;
    rstN        = 1'b0;
    instr       = '0;
    start       = 1'b0;
    pcIsZero    = 1'b0;
    waitrequest = 1'b0;
    stall       = 1'b0;
    aluFlag     = 1'b0;
    endOfRun    = 1'b0;
    count       = 0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (count < numInstr) begin
      @(posedge clk);
      // New word once the FETCH cycle ends
      if (state == FETCH) begin
        takeBits(5, pick);
        takeBits(15, regs);
        takeBits(16, imm);
        instr <= makeInstr(int'(pick[4:0]), regs[14:0], imm[15:0]);
        count++;
      end
      takeBits(2, bits);
      waitrequest <= bits[1:0] == 2'b00;
      takeBits(2, bits);
      stall <= bits[1:0] == 2'b00;
      takeBits(2, bits);
      aluFlag <= bits[1:0] == 2'b00;
    end
    @(posedge clk);
    pcIsZero <= 1'b1;
    @(posedge clk);
    pcIsZero <= 1'b0;
    repeat (4) @(posedge clk);
    endOfRun <= 1'b1;
    @(posedge clk);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(watchdogTime);
    $display("Timeout: the run did not finish within %0d ns", watchdogTime);
    $display("sim failed");
    $finish;
  end

endmodule
